// ==== verification/mem_stimulus.dat ====
# cmd op addr data flag exp (hex); idle waits data cycles; fon/foff hold fetch_en
# flag 0 accepted, 1 req_error, 2 queue_overflow; exp = load doubleword or fetched word
# Reset contents, doubleword store and load order
req   0 10000000 0                0 0
req   0 100007f8 0                0 0
req   1 10000000 1122334455667788 0 0
req   1 10000008 a5a5a5a5c3c3c3c3 0 0
req   0 10000000 0                0 1122334455667788
req   0 10000008 0                0 a5a5a5a5c3c3c3c3
# Byte store into lane 3
req   2 10000003 ee               0 0
req   0 10000000 0                0 11223344ee667788
# Misaligned and out of range requests
req   0 10000004 0                1 0
req   1 1000000c ffff             1 0
req   1 0ffffff8 ffff             1 0
req   2 10000800 ff               1 0
req   0 10000008 0                0 a5a5a5a5c3c3c3c3
# Fetch halves after the queue settles
idle  0 0        8                0 0
fetch 0 10000008 0                0 c3c3c3c3
fetch 0 1000000c 0                0 a5a5a5a5
fetch 0 10000004 0                0 11223344
# Loads held behind a fetch burst
idle  0 0        8                0 0
fon   0 10000000 0                0 0
req   1 10000010 0102030405060708 0 0
req   0 10000010 0                0 0102030405060708
req   0 10000000 0                0 11223344ee667788
idle  0 0        6                0 0
foff  0 0        0                0 0
idle  0 0        8                0 0
# Overflow while fetching, last request dropped
fon   0 10000000 0                0 0
req   1 10000018 deadbeefcafef00d 0 0
req   0 10000018 0                0 deadbeefcafef00d
req   2 10000021 5a               0 0
req   0 10000010 0                0 0102030405060708
req   1 10000018 ffffffffffffffff 2 0
idle  0 0        4                0 0
foff  0 0        0                0 0
idle  0 0        8                0 0
req   0 10000018 0                0 deadbeefcafef00d
req   0 10000020 0                0 0000000000005a00

// ==== compile.f ====
hdl/mem_map_pkg.sv
hdl/lsu_req_pkg.sv
hdl/mem_req_decode.sv
hdl/mem_req_queue.sv
hdl/data_mem.sv
hdl/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
# Exit status is nonzero when the build fails or the testbench stops on an error.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -f compile.f \
    --top-module tb_mem_subsystem --Mdir obj_dir -o sim_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== verification/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Testbench for the data memory subsystem
//  Stimulus and expected results read from a data file
//  Reference memory model updated in request order
//  Strobe, load and fetch checks on the falling edge
//////////////////////////////////////////////////////////////////////

module tb_mem_subsystem;
    import mem_map_pkg::*;
    import lsu_req_pkg::*;

    localparam logic [63:0] SEG_BASE    = DATA_START;
    localparam int          DATA_WORDS  = 256;
    localparam int          QUEUE_DEPTH = 4;
    localparam int          IDX_W       = $clog2(DATA_WORDS);
    localparam logic [63:0] SEG_END     = SEG_BASE + 64'(DATA_WORDS * WORD_BYTES);
    localparam int          DRAIN_LIMIT = 200; // Cycles allowed for pending loads

    // Stimulus commands, first column of the data file
    localparam logic [63:0] CMD_REQ   = 64'("req");
    localparam logic [63:0] CMD_FETCH = 64'("fetch");
    localparam logic [63:0] CMD_FON   = 64'("fon");
    localparam logic [63:0] CMD_FOFF  = 64'("foff");
    localparam logic [63:0] CMD_IDLE  = 64'("idle");

    logic        clk;
    logic        reset;
    logic        req_valid;
    mem_op_e     req_op;
    logic [63:0] req_addr;
    logic [63:0] req_wdata;
    logic        fetch_en;
    logic [63:0] fetch_addr;
    logic        fetch_valid;
    logic [31:0] inst;
    logic        load_valid;
    logic [63:0] load_data;
    logic        req_error;
    logic        queue_overflow;

    mem_word_u   model_mem [DATA_WORDS]; // Reference memory
    logic [63:0] exp_loads [$];          // Expected load results in order
    int          exp_lines [$];          // Stimulus line of each pending load

    // Driver state for the current cycle
    logic        fetch_hold;             // Burst keeps fetch_en high
    logic [63:0] cur_flag;
    logic        cur_fetch_chk;
    logic [31:0] cur_inst;
    int          cur_line;
    // One-cycle delayed expectations
    logic        err_pipe;
    logic        ovf_pipe;
    logic        fv_pipe;
    logic        inst_chk_pipe;
    logic [31:0] inst_pipe;
    int          line_pipe;
    logic [63:0] exp_word;
    int          exp_ln;

    mem_subsystem_top #(
        .DATA_START  (SEG_BASE),
        .DATA_WORDS  (DATA_WORDS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .fetch_en       (fetch_en),
        .fetch_addr     (fetch_addr),
        .fetch_valid    (fetch_valid),
        .inst           (inst),
        .load_valid     (load_valid),
        .load_data      (load_data),
        .req_error      (req_error),
        .queue_overflow (queue_overflow)
    );

    always #10 clk = ~clk; // 20 ns period

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and reference rules
    //////////////////////////////////////////////////////////////////////

    task automatic fail_plain(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic fail_value(input string what, input int line_no,
                              input logic [63:0] expected, input logic [63:0] actual);
        fail_plain($sformatf("ERR %s (stimulus line %0d): expected %h, actual %h",
                             what, line_no, expected, actual));
    endtask

    // Segment window, then 8-byte alignment for doubleword ops
    function automatic logic req_rejected(input mem_op_e op, input logic [63:0] addr);
        logic in_seg;
        logic misaligned;
        in_seg     = (addr >= SEG_BASE) && (addr < SEG_END);
        misaligned = (op != OP_STORE_B) && (addr[2:0] != 3'b000);
        return !in_seg || misaligned;
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [63:0] addr);
        logic [63:0] word_no;
        word_no = (addr - SEG_BASE) / 64'(WORD_BYTES);
        return IDX_W'(word_no); // Word number inside the segment
    endfunction

    // Strobes drop at each new cycle unless set again
    task automatic next_cycle();
        @(posedge clk);
        #1;
        req_valid     = 1'b0;
        fetch_en      = fetch_hold;
        cur_flag      = '0;
        cur_fetch_chk = 1'b0;
    endtask

    task automatic issue_request(input mem_op_e op, input logic [63:0] addr,
                                 input logic [63:0] data, input logic [63:0] flag,
                                 input logic [63:0] exp_data, input int line_no);
        logic             rejected;
        logic [IDX_W-1:0] idx;
        rejected = req_rejected(op, addr);
        idx      = word_index(addr);
        assert (rejected == (flag == 64'd1)) else
            fail_value("model error flag", line_no, 64'(flag == 64'd1), 64'(rejected));
        if (!rejected && flag != 64'd2) begin // Overflowed request is dropped
            case (op)
                OP_STORE_D: model_mem[idx].dword = data;
                // Base is word aligned, so addr[2:0] is the lane
                OP_STORE_B: model_mem[idx].dword[{addr[2:0], 3'b000} +: 8] = data[7:0];
                default: begin
                    assert (model_mem[idx].dword == exp_data) else
                        fail_value("model load", line_no, exp_data, model_mem[idx].dword);
                    exp_loads.push_back(model_mem[idx].dword);
                    exp_lines.push_back(line_no);
                end
            endcase
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = data;
        cur_flag  = flag;
        cur_line  = line_no;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output checks, half a cycle after each edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset) begin
            assert (req_error == err_pipe) else
                fail_value("req_error", line_pipe, 64'(err_pipe), 64'(req_error));
            assert (queue_overflow == ovf_pipe) else
                fail_value("queue_overflow", line_pipe, 64'(ovf_pipe), 64'(queue_overflow));
            assert (fetch_valid == fv_pipe) else
                fail_value("fetch_valid", line_pipe, 64'(fv_pipe), 64'(fetch_valid));
            if (inst_chk_pipe) begin
                assert (inst == inst_pipe) else
                    fail_value("inst", line_pipe, 64'(inst_pipe), 64'(inst));
            end
            if (load_valid) begin
                assert (exp_loads.size() > 0) else
                    fail_plain("Load result arrived with no load pending");
                assert (!fv_pipe) else
                    fail_plain("Load completed in the cycle right after a fetch");
                exp_word = exp_loads.pop_front();
                exp_ln   = exp_lines.pop_front();
                assert (load_data == exp_word) else
                    fail_value("load_data", exp_ln, exp_word, load_data);
            end
            err_pipe      = req_valid && (cur_flag == 64'd1);
            ovf_pipe      = req_valid && (cur_flag == 64'd2);
            fv_pipe       = fetch_en;
            inst_chk_pipe = cur_fetch_chk;
            inst_pipe     = cur_inst;
            line_pipe     = cur_line;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          fields;
        int          line_no;
        int          wait_cnt;
        int unsigned gap;
        string       line;
        logic [63:0] cmd;
        logic [63:0] f_op;
        logic [63:0] f_addr;
        logic [63:0] f_data;
        logic [63:0] f_flag;
        logic [63:0] f_exp;

        clk        = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_op     = OP_LOAD_D;
        req_addr   = '0;
        req_wdata  = '0;
        fetch_en   = 1'b0;
        fetch_addr = SEG_BASE;
        fetch_hold = 1'b0;
        cur_flag   = '0;
        cur_fetch_chk = 1'b0;
        cur_inst   = '0;
        cur_line   = 0;
        err_pipe   = 1'b0;
        ovf_pipe   = 1'b0;
        fv_pipe    = 1'b0;
        inst_chk_pipe = 1'b0;
        inst_pipe  = '0;
        line_pipe  = 0;
        line_no    = 0;
        gap        = $urandom(26); // Seed once
        for (int i = 0; i < DATA_WORDS; i++) begin
            model_mem[i] = '0; // Array clears on reset
        end

        fd = $fopen("verification/mem_stimulus.dat", "r");
        if (fd == 0) fail_plain("Cannot open verification/mem_stimulus.dat");

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") continue; // Comment or blank
            fields = $sscanf(line, "%s %h %h %h %h %h", cmd, f_op, f_addr, f_data, f_flag, f_exp);
            if (fields != 6) fail_plain($sformatf("Malformed stimulus line %0d", line_no));
            case (cmd)
                CMD_REQ: begin
                    next_cycle();
                    issue_request(mem_op_e'(f_op[1:0]), f_addr, f_data, f_flag, f_exp, line_no);
                end
                CMD_FETCH: begin
                    next_cycle();
                    cur_inst = model_mem[word_index(f_addr)].inst[f_addr[2]];
                    assert (cur_inst == f_exp[31:0]) else
                        fail_value("model fetch", line_no, f_exp, 64'(cur_inst));
                    fetch_en      = 1'b1;
                    fetch_addr    = f_addr;
                    cur_fetch_chk = 1'b1;
                    cur_line      = line_no;
                end
                CMD_FON: begin
                    next_cycle();
                    fetch_hold = 1'b1;
                    fetch_en   = 1'b1;
                    fetch_addr = f_addr;
                end
                CMD_FOFF: begin
                    next_cycle();
                    fetch_hold = 1'b0;
                    fetch_en   = 1'b0;
                end
                CMD_IDLE: repeat (f_data) next_cycle();
                default:  fail_plain($sformatf("Unknown command on stimulus line %0d", line_no));
            endcase
            if (cmd != CMD_IDLE) begin
                gap = $urandom_range(2, 0); // Random idle gap
                repeat (gap) next_cycle();
            end
        end
        $fclose(fd);

        // Drain pending loads
        fetch_hold = 1'b0;
        next_cycle();
        for (wait_cnt = 0; wait_cnt < DRAIN_LIMIT && exp_loads.size() > 0; wait_cnt++) begin
            next_cycle();
        end
        if (exp_loads.size() > 0) begin
            fail_plain("Timeout waiting for queued load results");
        end else begin
            repeat (QUEUE_DEPTH + 2) next_cycle(); // Last strobes checked
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule : tb_mem_subsystem

`default_nettype wire

// ==== hdl/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Data memory subsystem top level
//  Request decoder, request queue, memory array
//  Parameters for segment base, array depth, queue depth
//////////////////////////////////////////////////////////////////////

module mem_subsystem_top #(
    parameter logic [63:0] DATA_START  = mem_map_pkg::DATA_START,
    parameter int          DATA_WORDS  = 256,
    parameter int          QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    // Request strobe, no back-pressure
    input  logic                              req_valid,
    input  lsu_req_pkg::mem_op_e              req_op,
    input  logic [63:0]                       req_addr,
    input  logic [lsu_req_pkg::DATA_W-1:0]    req_wdata,
    // Instruction fetch
    input  logic                              fetch_en,
    input  logic [63:0]                       fetch_addr,
    output logic                              fetch_valid,
    output logic [31:0]                       inst,
    // Load results
    output logic                              load_valid,
    output logic [63:0]                       load_data,
    // Error strobes
    output logic                              req_error,
    output logic                              queue_overflow
);
    import lsu_req_pkg::*;

    localparam int IDX_W = $clog2(DATA_WORDS);

    //////////////////////////////////////////////////////////////////////
    // Decoder to queue
    //////////////////////////////////////////////////////////////////////

    logic              push;
    mem_op_e           push_op;
    logic [IDX_W-1:0]  push_index;
    logic [LANE_W-1:0] push_lane;
    logic [DATA_W-1:0] push_data;

    // Queue to array
    logic              pop_valid;
    logic              pop_ready;
    mem_op_e           pop_op;
    logic [IDX_W-1:0]  pop_index;
    logic [LANE_W-1:0] pop_lane;
    logic [DATA_W-1:0] pop_data;

    mem_req_decode #(
        .DATA_START (DATA_START),
        .DATA_WORDS (DATA_WORDS)
    ) decode0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .push       (push),
        .push_op    (push_op),
        .push_index (push_index),
        .push_lane  (push_lane),
        .push_data  (push_data),
        .req_error  (req_error)
    );

    mem_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .INDEX_W     (IDX_W)
    ) queue0 (
        .clk            (clk),
        .reset          (reset),
        .push           (push),
        .push_op        (push_op),
        .push_index     (push_index),
        .push_lane      (push_lane),
        .push_data      (push_data),
        .pop_valid      (pop_valid),
        .pop_op         (pop_op),
        .pop_index      (pop_index),
        .pop_lane       (pop_lane),
        .pop_data       (pop_data),
        .pop_ready      (pop_ready),
        .queue_overflow (queue_overflow)
    );

    data_mem #(
        .DATA_WORDS (DATA_WORDS)
    ) mem0 (
        .clk         (clk),
        .reset       (reset),
        .pop_valid   (pop_valid),
        .pop_op      (pop_op),
        .pop_index   (pop_index),
        .pop_lane    (pop_lane),
        .pop_data    (pop_data),
        .pop_ready   (pop_ready),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .inst        (inst),
        .load_valid  (load_valid),
        .load_data   (load_data)
    );

endmodule : mem_subsystem_top

`default_nettype wire

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Data memory array
//  64-bit words cleared on reset
//  Instruction fetch port with priority over data requests
//  Doubleword load/store and byte store from the request queue
//////////////////////////////////////////////////////////////////////

module data_mem #(
    parameter int DATA_WORDS = 256
) (
    input  logic                              clk,
    input  logic                              reset,
    // Queued data request
    input  logic                              pop_valid,
    input  lsu_req_pkg::mem_op_e              pop_op,
    input  logic [$clog2(DATA_WORDS)-1:0]     pop_index,
    input  logic [lsu_req_pkg::LANE_W-1:0]    pop_lane,
    input  logic [lsu_req_pkg::DATA_W-1:0]    pop_data,
    output logic                              pop_ready,
    // Fetch port
    input  logic                              fetch_en,
    input  logic [63:0]                       fetch_addr,
    output logic                              fetch_valid,
    output logic [31:0]                       inst,
    // Load response
    output logic                              load_valid,
    output logic [63:0]                       load_data
);
    import mem_map_pkg::*;
    import lsu_req_pkg::*;

    localparam int IDX_W = $clog2(DATA_WORDS);

    mem_word_u        mem [DATA_WORDS];
    logic [IDX_W-1:0] fetch_index;
    logic             data_op;   // Queue entry consumed this cycle
    logic             load_op;

    assign pop_ready = !fetch_en;             // Fetch owns the array
    assign data_op   = pop_valid && pop_ready;
    assign load_op   = data_op && (pop_op == OP_LOAD_D);

    // Segment base is aligned to the segment size
    // so the low address bits already give the offset
    assign fetch_index = fetch_addr[BYTE_SHIFT +: IDX_W];

    //////////////////////////////////////////////////////////////////////
    // Array writes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (data_op) begin
            case (pop_op)
                OP_STORE_D: mem[pop_index].dword <= pop_data;
                // Only the addressed lane changes
                OP_STORE_B: mem[pop_index].dword[{pop_lane, 3'b000} +: 8] <= pop_data[7:0];
                default:    ; // Loads only read
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
            load_valid  <= 1'b0;
        end else begin
            fetch_valid <= fetch_en; // Fixed one-cycle fetch
            load_valid  <= load_op;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_en) begin
            inst <= mem[fetch_index].inst[fetch_addr[2]]; // Bit 2 picks the half
        end
        if (load_op) begin
            load_data <= mem[pop_index].dword;
        end
    end

    // Fetch blocks the data side, so a load never completes right after one
    a_fetch_blocks_data: assert property (@(posedge clk) disable iff (reset)
        fetch_en |=> !load_valid);

endmodule : data_mem

`default_nettype wire

// ==== hdl/mem_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Decoded request queue
//  Circular buffer with read/write pointers and entry count
//  Push and pop in the same cycle
//  Overflow strobe on a dropped push
//////////////////////////////////////////////////////////////////////

module mem_req_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int INDEX_W     = 8   // Word index width of the array
) (
    input  logic                              clk,
    input  logic                              reset,
    // From the decoder
    input  logic                              push,
    input  lsu_req_pkg::mem_op_e              push_op,
    input  logic [INDEX_W-1:0]                push_index,
    input  logic [lsu_req_pkg::LANE_W-1:0]    push_lane,
    input  logic [lsu_req_pkg::DATA_W-1:0]    push_data,
    // Toward the array
    output logic                              pop_valid,
    output lsu_req_pkg::mem_op_e              pop_op,
    output logic [INDEX_W-1:0]                pop_index,
    output logic [lsu_req_pkg::LANE_W-1:0]    pop_lane,
    output logic [lsu_req_pkg::DATA_W-1:0]    pop_data,
    input  logic                              pop_ready,
    output logic                              queue_overflow
);
    import lsu_req_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Entry storage
    mem_op_e            op_q    [QUEUE_DEPTH];
    logic [INDEX_W-1:0] index_q [QUEUE_DEPTH];
    logic [LANE_W-1:0]  lane_q  [QUEUE_DEPTH];
    logic [DATA_W-1:0]  data_q  [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // Wrap at QUEUE_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign full           = (count == CNT_W'(QUEUE_DEPTH));
    assign do_pop         = pop_valid && pop_ready;
    assign do_push        = push && (!full || do_pop); // Pop frees a slot this cycle
    assign queue_overflow = push && full && !do_pop;   // Request dropped

    // Head entry
    assign pop_valid = (count != '0);
    assign pop_op    = op_q[rd_ptr];
    assign pop_index = index_q[rd_ptr];
    assign pop_lane  = lane_q[rd_ptr];
    assign pop_data  = data_q[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            op_q[wr_ptr]    <= push_op;
            index_q[wr_ptr] <= push_index;
            lane_q[wr_ptr]  <= push_lane;
            data_q[wr_ptr]  <= push_data;
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(QUEUE_DEPTH));

    // Equal pointers below full means empty
    a_empty_no_pop: assert property (@(posedge clk) disable iff (reset)
        ((rd_ptr == wr_ptr) && !full) |-> !pop_valid);

endmodule : mem_req_queue

`default_nettype wire

// ==== hdl/mem_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Request decoder
//  Segment window and alignment checks on request strobes
//  Word index and byte lane from the segment offset
//  Registered push toward the request queue, or an error strobe
//////////////////////////////////////////////////////////////////////

module mem_req_decode #(
    parameter logic [63:0] DATA_START = mem_map_pkg::DATA_START,
    parameter int          DATA_WORDS = 256
) (
    input  logic                              clk,
    input  logic                              reset,
    // Incoming request strobe
    input  logic                              req_valid,
    input  lsu_req_pkg::mem_op_e              req_op,
    input  logic [63:0]                       req_addr,
    input  logic [lsu_req_pkg::DATA_W-1:0]    req_wdata,
    // Toward the queue
    output logic                              push,
    output lsu_req_pkg::mem_op_e              push_op,
    output logic [$clog2(DATA_WORDS)-1:0]     push_index,
    output logic [lsu_req_pkg::LANE_W-1:0]    push_lane,
    output logic [lsu_req_pkg::DATA_W-1:0]    push_data,
    output logic                              req_error
);
    import mem_map_pkg::*;
    import lsu_req_pkg::*;

    localparam int IDX_W = $clog2(DATA_WORDS);
    // First byte past the segment
    localparam logic [63:0] SEG_END = DATA_START + 64'(DATA_WORDS) * 64'(WORD_BYTES);

    logic [63:0] offset;   // Byte offset into the segment
    logic        in_range;
    logic        aligned;
    logic        op_known;
    logic        accept;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    assign offset   = req_addr - DATA_START;
    assign in_range = (req_addr >= DATA_START) && (req_addr < SEG_END);
    assign aligned  = !op_is_dword(req_op) || (req_addr[BYTE_SHIFT-1:0] == '0);
    assign op_known = req_op inside {OP_LOAD_D, OP_STORE_D, OP_STORE_B};
    assign accept   = in_range && aligned && op_known;

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            push      <= 1'b0;
            req_error <= 1'b0;
        end else begin
            push      <= req_valid && accept;  // One strobe per good request
            req_error <= req_valid && !accept; // Rejects never reach the queue
        end
    end

    // Payload held until the next accepted request
    always_ff @(posedge clk) begin
        if (req_valid && accept) begin
            push_op    <= req_op;
            push_index <= offset[BYTE_SHIFT +: IDX_W]; // Offset / 8
            push_lane  <= offset[LANE_W-1:0];
            push_data  <= req_wdata;
        end
    end

    // Accept and reject never strobe together
    a_push_or_error: assert property (@(posedge clk) disable iff (reset)
        !(push && req_error));

endmodule : mem_req_decode

`default_nettype wire

// ==== hdl/lsu_req_pkg.sv ====
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Data request definitions
//  Operation codes for loads and stores
//  Field widths of a decoded request
//  Operation class helper for the alignment check
//////////////////////////////////////////////////////////////////////

package lsu_req_pkg;

    //////////////////////////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_LOAD_D  = 2'b00, // Load doubleword
        OP_STORE_D = 2'b01, // Store doubleword
        OP_STORE_B = 2'b10  // Store low data byte into one lane
    } mem_op_e;
    // Code 2'b11 has no meaning and gets rejected

    //////////////////////////////////////////////////////////////////////
    // Decoded request fields
    //////////////////////////////////////////////////////////////////////

    localparam int LANE_W = 3;  // Byte lane inside a doubleword
    localparam int DATA_W = 64; // Write data carried with every request

    // Doubleword ops need an 8-byte aligned address
    function automatic logic op_is_dword(input mem_op_e op);
        logic is_dword;
        is_dword = (op == OP_LOAD_D) || (op == OP_STORE_D);
        return is_dword;
    endfunction

endpackage : lsu_req_pkg

`default_nettype wire

// ==== hdl/mem_map_pkg.sv ====
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Memory map definitions for the data memory side
//  Default data segment base address
//  Word geometry and address split
//  Memory word union with doubleword and instruction views
//////////////////////////////////////////////////////////////////////

package mem_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // Segment and word geometry
    //////////////////////////////////////////////////////////////////////

    localparam logic [63:0] DATA_START = 64'h10000000; // Default segment base

    localparam int WORD_BITS  = 64;                // Array word width
    localparam int WORD_BYTES = WORD_BITS / 8;     // 8 bytes per word
    localparam int BYTE_SHIFT = $clog2(WORD_BYTES); // Offset bits below word index

    // Instruction halves inside one word
    localparam int INST_BITS     = 32;
    localparam int INST_PER_WORD = WORD_BITS / INST_BITS;

    //////////////////////////////////////////////////////////////////////
    // Memory word
    //////////////////////////////////////////////////////////////////////

    // Data side sees one doubleword
    // Fetch side sees two instructions, picked by address bit 2
    typedef union packed {
        logic [WORD_BITS-1:0]                    dword; // Load/store view
        logic [INST_PER_WORD-1:0][INST_BITS-1:0] inst;  // [0] is the low half
    } mem_word_u;

endpackage : mem_map_pkg

`default_nettype wire
